//--- Makefile
# Verilator build and run of the read demux testbench

VERILATOR ?= verilator
TOP       ?= tb_axi_rd_demux
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, check the log"
	@echo "  clean  remove build output and log"
	@echo "  help   this list"

$(BUILD_DIR)/V$(TOP): $(FILELIST) *.sv
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

test: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q "Regression passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- ar_route_ctrl.sv
`timescale 1ns/10ps

module ar_route_ctrl #(
  parameter int unsigned NUM_PORTS = axi_rd_demux_pkg::NUM_PORTS_DEF,
  localparam int unsigned SEL_WIDTH = (NUM_PORTS > 1) ? $clog2(NUM_PORTS) : 1
) (
  input  logic                 clk_i,
  input  logic                 rst_i,
  // slave side AR handshake and port select
  input  logic                 ar_valid_i,
  input  logic [SEL_WIDTH-1:0] ar_select_i,
  output logic                 ar_ready_o,
  // ordering state from the ID counters
  input  logic [SEL_WIDTH-1:0] lookup_select_i,
  input  logic                 lookup_occupied_i,
  input  logic                 full_i,
  output logic                 ar_push_o,
  // master side AR handshake
  output logic [NUM_PORTS-1:0] mst_ar_valid_o,
  input  logic [NUM_PORTS-1:0] mst_ar_ready_i
);

  logic [NUM_PORTS-1:0] sel_onehot;
  logic                 sel_ready;
  logic                 ar_valid;
  logic                 lock_d;
  logic                 lock_q;

  // --------------------------------------------------
  // port decode
  // --------------------------------------------------
  always_comb begin
    for (int unsigned i = 0; i < NUM_PORTS; i++) begin
      sel_onehot[i] = (ar_select_i == SEL_WIDTH'(i));
    end
  end

  // ready of the addressed port only
  assign sel_ready = |(mst_ar_ready_i & sel_onehot);

  // --------------------------------------------------
  // admission and handshake
  // --------------------------------------------------
  always_comb begin
    ar_valid   = 1'b0;
    ar_ready_o = 1'b0;
    ar_push_o  = 1'b0;
    lock_d     = lock_q;
    if (lock_q) begin
      // decision already shown on the master side, just wait for ready
      ar_valid = 1'b1;
      if (sel_ready) begin
        ar_ready_o = 1'b1;
        ar_push_o  = 1'b1;
        lock_d     = 1'b0;
      end
    end else if (!full_i && ar_valid_i &&
                 (!lookup_occupied_i || (ar_select_i == lookup_select_i))) begin
      // ID idle or still heading to the same port
      ar_valid = 1'b1;
      if (sel_ready) begin
        ar_ready_o = 1'b1;
        ar_push_o  = 1'b1;
      end else begin
        // keep valid up even if the counters change meanwhile
        lock_d = 1'b1;
      end
    end
  end

  // valid lock register
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      lock_q <= 1'b0;
    end else begin
      lock_q <= lock_d;
    end
  end

  // fan the valid out to the chosen port only
  assign mst_ar_valid_o = ar_valid ? sel_onehot : '0;

endmodule

//--- axi_rd_demux.sv
`timescale 1ns/10ps

module axi_rd_demux #(
  parameter int unsigned NUM_PORTS  = axi_rd_demux_pkg::NUM_PORTS_DEF,
  parameter int unsigned ID_WIDTH   = axi_rd_demux_pkg::ID_WIDTH_DEF,
  parameter int unsigned LOOK_BITS  = axi_rd_demux_pkg::LOOK_BITS_DEF,
  parameter int unsigned MAX_TRANS  = axi_rd_demux_pkg::MAX_TRANS_DEF,
  parameter int unsigned ADDR_WIDTH = axi_rd_demux_pkg::ADDR_WIDTH_DEF,
  parameter int unsigned DATA_WIDTH = axi_rd_demux_pkg::DATA_WIDTH_DEF,
  localparam int unsigned SEL_WIDTH = (NUM_PORTS > 1) ? $clog2(NUM_PORTS) : 1
) (
  input  logic                                                   clk_i,
  input  logic                                                   rst_i,
  // slave port AR
  input  logic [ID_WIDTH-1:0]                                    slv_ar_id_i,
  input  logic [ADDR_WIDTH-1:0]                                  slv_ar_addr_i,
  input  logic [axi_rd_demux_pkg::LEN_WIDTH-1:0]                 slv_ar_len_i,
  input  logic [SEL_WIDTH-1:0]                                   slv_ar_select_i,
  input  logic                                                   slv_ar_valid_i,
  output logic                                                   slv_ar_ready_o,
  // slave port R
  output logic [ID_WIDTH-1:0]                                    slv_r_id_o,
  output logic [DATA_WIDTH-1:0]                                  slv_r_data_o,
  output logic [axi_rd_demux_pkg::RESP_WIDTH-1:0]                slv_r_resp_o,
  output logic                                                   slv_r_last_o,
  output logic                                                   slv_r_valid_o,
  input  logic                                                   slv_r_ready_i,
  // master ports AR, payload shared by all ports
  output logic [ID_WIDTH-1:0]                                    mst_ar_id_o,
  output logic [ADDR_WIDTH-1:0]                                  mst_ar_addr_o,
  output logic [axi_rd_demux_pkg::LEN_WIDTH-1:0]                 mst_ar_len_o,
  output logic [NUM_PORTS-1:0]                                   mst_ar_valid_o,
  input  logic [NUM_PORTS-1:0]                                   mst_ar_ready_i,
  // master ports R
  input  logic [NUM_PORTS-1:0][ID_WIDTH-1:0]                     mst_r_id_i,
  input  logic [NUM_PORTS-1:0][DATA_WIDTH-1:0]                   mst_r_data_i,
  input  logic [NUM_PORTS-1:0][axi_rd_demux_pkg::RESP_WIDTH-1:0] mst_r_resp_i,
  input  logic [NUM_PORTS-1:0]                                   mst_r_last_i,
  input  logic [NUM_PORTS-1:0]                                   mst_r_valid_i,
  output logic [NUM_PORTS-1:0]                                   mst_r_ready_o
);

  logic [LOOK_BITS-1:0] ar_look_id;
  logic [LOOK_BITS-1:0] r_look_id;
  logic [SEL_WIDTH-1:0] lookup_select;
  logic                 lookup_occupied;
  logic                 cnt_full;
  logic                 ar_push;

  // --------------------------------------------------
  // AR payload broadcast and ID slices
  // --------------------------------------------------
  assign mst_ar_id_o   = slv_ar_id_i;
  assign mst_ar_addr_o = slv_ar_addr_i;
  assign mst_ar_len_o  = slv_ar_len_i;

  // counters only see the low ID bits
  assign ar_look_id = slv_ar_id_i[LOOK_BITS-1:0];
  assign r_look_id  = slv_r_id_o[LOOK_BITS-1:0];

  // --------------------------------------------------
  // ordering state
  // --------------------------------------------------
  rd_id_counters #(
    .NUM_PORTS (NUM_PORTS),
    .LOOK_BITS (LOOK_BITS),
    .MAX_TRANS (MAX_TRANS)
  ) u_counters (
    .clk_i             (clk_i),
    .rst_i             (rst_i),
    .lookup_id_i       (ar_look_id),
    .lookup_select_o   (lookup_select),
    .lookup_occupied_o (lookup_occupied),
    .full_o            (cnt_full),
    .push_id_i         (ar_look_id),
    .push_select_i     (slv_ar_select_i),
    .push_i            (ar_push),
    .r_id_i            (r_look_id),
    .r_last_i          (slv_r_last_o),
    .r_valid_i         (slv_r_valid_o),
    .r_ready_i         (slv_r_ready_i)
  );

  // --------------------------------------------------
  // AR admission and routing
  // --------------------------------------------------
  ar_route_ctrl #(
    .NUM_PORTS (NUM_PORTS)
  ) u_ar_ctrl (
    .clk_i             (clk_i),
    .rst_i             (rst_i),
    .ar_valid_i        (slv_ar_valid_i),
    .ar_select_i       (slv_ar_select_i),
    .ar_ready_o        (slv_ar_ready_o),
    .lookup_select_i   (lookup_select),
    .lookup_occupied_i (lookup_occupied),
    .full_i            (cnt_full),
    .ar_push_o         (ar_push),
    .mst_ar_valid_o    (mst_ar_valid_o),
    .mst_ar_ready_i    (mst_ar_ready_i)
  );

  // --------------------------------------------------
  // R merge
  // --------------------------------------------------
  r_rr_arbiter #(
    .NUM_PORTS  (NUM_PORTS),
    .ID_WIDTH   (ID_WIDTH),
    .DATA_WIDTH (DATA_WIDTH)
  ) u_r_arb (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .mst_r_valid_i (mst_r_valid_i),
    .mst_r_id_i    (mst_r_id_i),
    .mst_r_data_i  (mst_r_data_i),
    .mst_r_resp_i  (mst_r_resp_i),
    .mst_r_last_i  (mst_r_last_i),
    .mst_r_ready_o (mst_r_ready_o),
    .slv_r_valid_o (slv_r_valid_o),
    .slv_r_id_o    (slv_r_id_o),
    .slv_r_data_o  (slv_r_data_o),
    .slv_r_resp_o  (slv_r_resp_o),
    .slv_r_last_o  (slv_r_last_o),
    .slv_r_ready_i (slv_r_ready_i)
  );

endmodule

//--- axi_rd_demux_pkg.sv
package axi_rd_demux_pkg;

  // --------------------------------------------------
  // default sizes, overridden from the top level
  // --------------------------------------------------

  // number of master ports behind the demux
  localparam int unsigned NUM_PORTS_DEF  = 4;

  // full AXI ID width on slave and master side
  localparam int unsigned ID_WIDTH_DEF   = 4;

  // low ID bits that index the in-flight counters
  localparam int unsigned LOOK_BITS_DEF  = 2;

  // per-ID bound, counter width is log2 of this
  localparam int unsigned MAX_TRANS_DEF  = 4;

  // address and data bus widths
  localparam int unsigned ADDR_WIDTH_DEF = 32;
  localparam int unsigned DATA_WIDTH_DEF = 32;

  // --------------------------------------------------
  // protocol constants
  // --------------------------------------------------

  // arlen is always 8 bits wide in AXI4
  localparam int unsigned LEN_WIDTH  = 8;

  // rresp width and the codes in use
  localparam int unsigned RESP_WIDTH = 2;
  localparam logic [RESP_WIDTH-1:0] RESP_OKAY   = 2'b00;
  localparam logic [RESP_WIDTH-1:0] RESP_SLVERR = 2'b10;

endpackage

//--- r_rr_arbiter.sv
`timescale 1ns/10ps

module r_rr_arbiter #(
  parameter int unsigned NUM_PORTS  = axi_rd_demux_pkg::NUM_PORTS_DEF,
  parameter int unsigned ID_WIDTH   = axi_rd_demux_pkg::ID_WIDTH_DEF,
  parameter int unsigned DATA_WIDTH = axi_rd_demux_pkg::DATA_WIDTH_DEF,
  localparam int unsigned SEL_WIDTH = (NUM_PORTS > 1) ? $clog2(NUM_PORTS) : 1
) (
  input  logic                                                   clk_i,
  input  logic                                                   rst_i,
  // R channels of the master ports
  input  logic [NUM_PORTS-1:0]                                   mst_r_valid_i,
  input  logic [NUM_PORTS-1:0][ID_WIDTH-1:0]                     mst_r_id_i,
  input  logic [NUM_PORTS-1:0][DATA_WIDTH-1:0]                   mst_r_data_i,
  input  logic [NUM_PORTS-1:0][axi_rd_demux_pkg::RESP_WIDTH-1:0] mst_r_resp_i,
  input  logic [NUM_PORTS-1:0]                                   mst_r_last_i,
  output logic [NUM_PORTS-1:0]                                   mst_r_ready_o,
  // merged R channel on the slave port
  output logic                                                   slv_r_valid_o,
  output logic [ID_WIDTH-1:0]                                    slv_r_id_o,
  output logic [DATA_WIDTH-1:0]                                  slv_r_data_o,
  output logic [axi_rd_demux_pkg::RESP_WIDTH-1:0]                slv_r_resp_o,
  output logic                                                   slv_r_last_o,
  input  logic                                                   slv_r_ready_i
);

  // round-robin pointer, first port to look at
  logic [SEL_WIDTH-1:0] ptr_q;
  // winner held while the slave side stalls
  logic                 lock_q;
  logic [SEL_WIDTH-1:0] lock_idx_q;

  logic [SEL_WIDTH-1:0] pick;
  logic [SEL_WIDTH-1:0] win;
  logic [SEL_WIDTH-1:0] next_ptr;
  logic                 win_valid;

  // --------------------------------------------------
  // search from the pointer upwards with wrap
  // --------------------------------------------------
  always_comb begin
    logic [SEL_WIDTH-1:0] idx;
    logic                 found;
    idx   = '0;
    found = 1'b0;
    pick  = ptr_q;
    for (int unsigned k = 0; k < NUM_PORTS; k++) begin
      idx = SEL_WIDTH'((32'(ptr_q) + k) % NUM_PORTS);
      if (!found && mst_r_valid_i[idx]) begin
        found = 1'b1;
        pick  = idx;
      end
    end
  end

  // a locked beat wins over a fresh search
  assign win       = lock_q ? lock_idx_q : pick;
  assign win_valid = mst_r_valid_i[win];

  // step past the winner, wrap at the last port
  assign next_ptr = (win == SEL_WIDTH'(NUM_PORTS - 1)) ? '0 : win + SEL_WIDTH'(1);

  // --------------------------------------------------
  // data mux and ready fan-out
  // --------------------------------------------------
  assign slv_r_valid_o = win_valid;
  assign slv_r_id_o    = mst_r_id_i[win];
  assign slv_r_data_o  = mst_r_data_i[win];
  assign slv_r_resp_o  = mst_r_resp_i[win];
  assign slv_r_last_o  = mst_r_last_i[win];

  always_comb begin
    for (int unsigned i = 0; i < NUM_PORTS; i++) begin
      mst_r_ready_o[i] = win_valid && slv_r_ready_i && (win == SEL_WIDTH'(i));
    end
  end

  // --------------------------------------------------
  // pointer and lock-in
  // --------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      ptr_q      <= '0;
      lock_q     <= 1'b0;
      lock_idx_q <= '0;
    end else begin
      lock_q <= win_valid && !slv_r_ready_i;
      if (win_valid && !slv_r_ready_i) begin
        lock_idx_q <= win;
      end
      // advance only on a real transfer
      if (win_valid && slv_r_ready_i) begin
        ptr_q <= next_ptr;
      end
    end
  end

endmodule

//--- rd_id_counters.sv
`timescale 1ns/10ps

module rd_id_counters #(
  parameter int unsigned NUM_PORTS = axi_rd_demux_pkg::NUM_PORTS_DEF,
  parameter int unsigned LOOK_BITS = axi_rd_demux_pkg::LOOK_BITS_DEF,
  parameter int unsigned MAX_TRANS = axi_rd_demux_pkg::MAX_TRANS_DEF,
  localparam int unsigned SEL_WIDTH = (NUM_PORTS > 1) ? $clog2(NUM_PORTS) : 1
) (
  input  logic                 clk_i,
  input  logic                 rst_i,
  // lookup of the AR currently presented
  input  logic [LOOK_BITS-1:0] lookup_id_i,
  output logic [SEL_WIDTH-1:0] lookup_select_o,
  output logic                 lookup_occupied_o,
  output logic                 full_o,
  // push on every AR transfer
  input  logic [LOOK_BITS-1:0] push_id_i,
  input  logic [SEL_WIDTH-1:0] push_select_i,
  input  logic                 push_i,
  // slave side R channel, pops on the last beat
  input  logic [LOOK_BITS-1:0] r_id_i,
  input  logic                 r_last_i,
  input  logic                 r_valid_i,
  input  logic                 r_ready_i
);

  // one counter per value of the looked-up ID bits
  localparam int unsigned NUM_CNT   = 2 ** LOOK_BITS;
  localparam int unsigned CNT_WIDTH = (MAX_TRANS > 1) ? $clog2(MAX_TRANS) : 1;

  // in-flight bursts per ID index
  logic [CNT_WIDTH-1:0] cnt_q [NUM_CNT];
  // port that the open bursts of this ID index went to
  logic [SEL_WIDTH-1:0] sel_q [NUM_CNT];

  logic [NUM_CNT-1:0] push_en;
  logic [NUM_CNT-1:0] pop_en;
  logic [NUM_CNT-1:0] occupied;
  logic [NUM_CNT-1:0] cnt_full;
  logic               pop;

  // --------------------------------------------------
  // lookup
  // --------------------------------------------------
  assign lookup_select_o   = sel_q[lookup_id_i];
  assign lookup_occupied_o = occupied[lookup_id_i];

  // any full counter blocks all new ARs
  assign full_o = |cnt_full;

  // --------------------------------------------------
  // push and pop decode
  // --------------------------------------------------
  // a burst closes when its last beat leaves on the slave side
  assign pop = r_valid_i & r_ready_i & r_last_i;

  always_comb begin
    for (int unsigned i = 0; i < NUM_CNT; i++) begin
      push_en[i] = push_i && (push_id_i == LOOK_BITS'(i));
      pop_en[i]  = pop && (r_id_i == LOOK_BITS'(i));
    end
  end

  // --------------------------------------------------
  // counters and select registers
  // --------------------------------------------------
  for (genvar g = 0; g < NUM_CNT; g++) begin : gen_cnt

    // up on push, down on pop, both at once cancel out
    always_ff @(posedge clk_i) begin
      if (rst_i) begin
        cnt_q[g] <= '0;
      end else if (push_en[g] && !pop_en[g]) begin
        cnt_q[g] <= cnt_q[g] + CNT_WIDTH'(1);
      end else if (pop_en[g] && !push_en[g]) begin
        cnt_q[g] <= cnt_q[g] - CNT_WIDTH'(1);
      end
    end

    // only read while the counter is nonzero
    always_ff @(posedge clk_i) begin
      if (push_en[g]) begin
        sel_q[g] <= push_select_i;
      end
    end

    assign occupied[g] = |cnt_q[g];
    // all ones means MAX_TRANS-1 bursts open
    assign cnt_full[g] = &cnt_q[g];

  end

endmodule

//--- tb_axi_rd_demux.sv
`timescale 1ns/10ps

module tb_axi_rd_demux;
  import axi_rd_demux_pkg::*;

  localparam int NP = NUM_PORTS_DEF;
  localparam int NT = 12;

  // --------------------------------------------------
  // stimulus table
  // {ready mask, stall, resp, len, select, id}
  // a set mask bit makes that port's AR ready random instead of always high
  // --------------------------------------------------
  localparam logic [20:0] TABLE [NT] = '{
    {4'b0001, 1'b0, RESP_OKAY,   8'd3, 2'd0, 4'd1},
    {4'b0001, 1'b0, RESP_OKAY,   8'd1, 2'd0, 4'd1},
    {4'b0010, 1'b0, RESP_OKAY,   8'd0, 2'd1, 4'd2},
    {4'b0100, 1'b0, RESP_SLVERR, 8'd2, 2'd2, 4'd3},
    // same ID index as the bursts on port 0 but another port
    {4'b1000, 1'b1, RESP_OKAY,   8'd1, 2'd3, 4'd5},
    {4'b0000, 1'b0, RESP_OKAY,   8'd2, 2'd0, 4'd0},
    {4'b0001, 1'b0, RESP_OKAY,   8'd0, 2'd0, 4'd4},
    {4'b0001, 1'b0, RESP_SLVERR, 8'd1, 2'd0, 4'd8},
    // index 0 counter is full now
    {4'b0010, 1'b1, RESP_OKAY,   8'd0, 2'd1, 4'd6},
    {4'b1111, 1'b0, RESP_SLVERR, 8'd3, 2'd2, 4'd7},
    {4'b1000, 1'b0, RESP_OKAY,   8'd0, 2'd3, 4'd9},
    {4'b0010, 1'b0, RESP_OKAY,   8'd2, 2'd1, 4'd10}
  };

  logic clk_i, rst_i;
  logic [3:0] slv_ar_id_i;
  logic [31:0] slv_ar_addr_i;
  logic [7:0] slv_ar_len_i;
  logic [1:0] slv_ar_select_i;
  logic slv_ar_valid_i, slv_ar_ready_o;
  logic [3:0] slv_r_id_o;
  logic [31:0] slv_r_data_o;
  logic [1:0] slv_r_resp_o;
  logic slv_r_last_o, slv_r_valid_o, slv_r_ready_i;
  logic [3:0] mst_ar_id_o;
  logic [31:0] mst_ar_addr_o;
  logic [7:0] mst_ar_len_o;
  logic [NP-1:0] mst_ar_valid_o, mst_ar_ready_i;
  logic [NP-1:0][3:0] mst_r_id_i;
  logic [NP-1:0][31:0] mst_r_data_i;
  logic [NP-1:0][1:0] mst_r_resp_i;
  logic [NP-1:0] mst_r_last_i, mst_r_valid_i, mst_r_ready_o, r_fired;

  // open bursts {resp, len, id} and expected beats {last, resp, id, data} per port
  logic [13:0] burst_q [NP][$];
  logic [38:0] exp_q [NP][$];
  int beat_idx [NP];
  // reference ordering state with counters and remembered port per ID index
  int ref_cnt [4];
  logic [1:0] ref_sel [4];
  logic r_enable;
  logic [3:0] rdy_mask;
  logic [1:0] cur_resp;
  logic timed_out = 1'b0;
  integer seed = 32'h861c;
  int val_err = 0;
  int proto_err = 0;

  axi_rd_demux dut (.*);

  always #4 clk_i = ~clk_i;

  // beat payload that is unique per id, port and beat index
  function automatic logic [31:0] beat_data(logic [3:0] id, int port, int beat);
    return {4'hd, id, 8'(port), 8'(beat), 8'(id * 16 + port * 4 + beat) ^ 8'h3c};
  endfunction

  // admission stall predicted by the reference counters for an ID index and port
  function automatic logic predict_stall(int look, logic [1:0] sel);
    logic any_full;
    any_full = 1'b0;
    for (int i = 0; i < 4; i++) begin
      if (ref_cnt[i] == int'(MAX_TRANS_DEF) - 1) begin
        any_full = 1'b1;
      end
    end
    return any_full || (ref_cnt[look] != 0 && ref_sel[look] != sel);
  endfunction

  task automatic check_val(string name, logic [31:0] got, logic [31:0] exp);
    if (got !== exp) begin
      $display("FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
      val_err++;
    end
  endtask

  task automatic note_timeout(string what);
    $display("timeout while waiting for %s", what);
    proto_err++;
    timed_out = 1'b1;
  endtask

  // --------------------------------------------------
  // master-side slave models
  // --------------------------------------------------
  always @(posedge clk_i) begin
    r_fired <= mst_r_valid_i & mst_r_ready_o;
    for (int p = 0; p < NP; p++) begin
      if (!rst_i && mst_ar_valid_o[p] && mst_ar_ready_i[p]) begin
        burst_q[p].push_back({cur_resp, mst_ar_len_o, mst_ar_id_o});
        for (int b = 0; b <= int'(mst_ar_len_o); b++) begin
          exp_q[p].push_back({b == int'(mst_ar_len_o), cur_resp, mst_ar_id_o,
                              beat_data(mst_ar_id_o, p, b)});
        end
      end
    end
  end

  always @(negedge clk_i) begin
    logic [13:0] b;
    slv_r_ready_i = ($random(seed) & 3) != 0;
    for (int p = 0; p < NP; p++) begin
      mst_ar_ready_i[p] = rdy_mask[p] ? 1'($random(seed)) : 1'b1;
      if (r_fired[p]) begin
        if (mst_r_last_i[p]) begin
          void'(burst_q[p].pop_front());
          beat_idx[p] = 0;
        end else begin
          beat_idx[p]++;
        end
        mst_r_valid_i[p] = 1'b0;
      end
      // a shown beat stays until taken
      if (!rst_i && !mst_r_valid_i[p] && r_enable && burst_q[p].size() > 0) begin
        b = burst_q[p][0];
        mst_r_valid_i[p] = 1'b1;
        mst_r_id_i[p]    = b[3:0];
        mst_r_resp_i[p]  = b[13:12];
        mst_r_last_i[p]  = beat_idx[p] == int'(b[11:4]);
        mst_r_data_i[p]  = beat_data(b[3:0], p, beat_idx[p]);
      end
    end
  end

  // --------------------------------------------------
  // scoreboard and reference counters
  // --------------------------------------------------
  always @(posedge clk_i) begin
    int hit;
    hit = -1;
    if (!rst_i && slv_r_valid_o && slv_r_ready_i) begin
      for (int p = 0; p < NP; p++) begin
        if (hit < 0 && exp_q[p].size() > 0 && exp_q[p][0][31:0] == slv_r_data_o) begin
          hit = p;
        end
      end
      if (hit < 0) begin
        $display("R beat with data %h at %0t matches no expected beat",
                 slv_r_data_o, $time);
        proto_err++;
      end else begin
        check_val("slv_r_id_o", 32'(slv_r_id_o), 32'(exp_q[hit][0][35:32]));
        check_val("slv_r_resp_o", 32'(slv_r_resp_o), 32'(exp_q[hit][0][37:36]));
        check_val("slv_r_last_o", 32'(slv_r_last_o), 32'(exp_q[hit][0][38]));
        // only the source port of the forwarded beat may hand one over
        check_val("mst_r_ready_o", 32'(mst_r_valid_i & mst_r_ready_o), 32'(1) << hit);
        void'(exp_q[hit].pop_front());
      end
    end else if (!rst_i) begin
      // no slave transfer, so no master beat may be taken
      check_val("mst_r_ready_o", 32'(mst_r_valid_i & mst_r_ready_o), 0);
    end
    for (int i = 0; i < 4; i++) begin
      ref_cnt[i] <= ref_cnt[i]
        + int'(!rst_i && slv_ar_valid_i && slv_ar_ready_o && int'(slv_ar_id_i[1:0]) == i)
        - int'(!rst_i && slv_r_valid_o && slv_r_ready_i && slv_r_last_o &&
               int'(slv_r_id_o[1:0]) == i);
      if (slv_ar_valid_i && slv_ar_ready_o && int'(slv_ar_id_i[1:0]) == i) begin
        ref_sel[i] <= slv_ar_select_i;
      end
    end
  end

  // --------------------------------------------------
  // main sequence
  // --------------------------------------------------
  initial begin
    logic [20:0] e;
    logic stall_exp, stall_ref, done;
    int idx, t;
    clk_i = 0;
    rst_i = 1;
    r_enable = 0;
    rdy_mask = '0;
    cur_resp = RESP_OKAY;
    slv_ar_id_i = '0;
    slv_ar_addr_i = '0;
    slv_ar_len_i = '0;
    slv_ar_select_i = '0;
    slv_ar_valid_i = 0;
    slv_r_ready_i = 0;
    mst_ar_ready_i = '0;
    mst_r_valid_i = '0;
    mst_r_id_i = '0;
    mst_r_data_i = '0;
    mst_r_resp_i = '0;
    mst_r_last_i = '0;
    r_fired = '0;
    for (int i = 0; i < 4; i++) begin
      ref_cnt[i] = 0;
      ref_sel[i] = '0;
      beat_idx[i] = 0;
    end
    repeat (4) @(posedge clk_i);
    @(negedge clk_i);
    rst_i = 0;
    for (int n = 0; n < NT && !timed_out; n++) begin
      e = TABLE[n];
      stall_exp = e[16];
      idx = int'(e[1:0]);
      slv_ar_id_i = e[3:0];
      slv_ar_select_i = e[5:4];
      slv_ar_len_i = e[13:6];
      slv_ar_addr_i = 32'h1000_0000 + 32'(n) * 32'h40;
      cur_resp = e[15:14];
      // the port models pick up the new mask from the next falling edge
      rdy_mask <= e[20:17];
      slv_ar_valid_i = 1;
      @(posedge clk_i);
      // admission from the ordering rules alone
      stall_ref = predict_stall(idx, slv_ar_select_i);
      if (stall_ref != stall_exp) begin
        $display("entry %0d: ordering state does not give the expected stall", n);
        proto_err++;
      end
      if (stall_exp) begin
        // nothing drains yet, so the stall must hold
        for (int c = 0; c < 5; c++) begin
          if (c > 0) @(posedge clk_i);
          check_val("slv_ar_ready_o", 32'(slv_ar_ready_o), 0);
          check_val("mst_ar_valid_o", 32'(mst_ar_valid_o), 0);
        end
        @(negedge clk_i);
        r_enable <= 1'b1;
        @(posedge clk_i);
      end
      done = 0;
      t = 0;
      while (!done && !timed_out) begin
        // routing expected from the reference state of this cycle
        stall_ref = predict_stall(idx, slv_ar_select_i);
        check_val("mst_ar_valid_o", 32'(mst_ar_valid_o),
                  stall_ref ? 32'(0) : 32'(1) << slv_ar_select_i);
        check_val("slv_ar_ready_o", 32'(slv_ar_ready_o),
                  32'(!stall_ref && mst_ar_ready_i[slv_ar_select_i]));
        if (mst_ar_valid_o != 0) begin
          check_val("mst_ar_id_o", 32'(mst_ar_id_o), 32'(slv_ar_id_i));
          check_val("mst_ar_addr_o", mst_ar_addr_o, slv_ar_addr_i);
          check_val("mst_ar_len_o", 32'(mst_ar_len_o), 32'(slv_ar_len_i));
        end
        done = slv_ar_ready_o;
        if (!done) begin
          t++;
          if (t > 300) begin
            note_timeout("AR acceptance");
          end else begin
            @(posedge clk_i);
          end
        end
      end
      @(negedge clk_i);
      slv_ar_valid_i = 0;
      r_enable <= 1'b0;
    end
    // let every open burst drain
    r_enable <= 1'b1;
    t = 0;
    while (!timed_out &&
           exp_q[0].size() + exp_q[1].size() + exp_q[2].size() + exp_q[3].size() > 0) begin
      t++;
      if (t > 3000) begin
        note_timeout("the R beats to drain");
      end else begin
        @(posedge clk_i);
      end
    end
    repeat (2) @(posedge clk_i);
    for (int i = 0; i < 4; i++) begin
      check_val("ref_cnt", 32'(ref_cnt[i]), 0);
    end
    $display("errors: %0d value, %0d protocol", val_err, proto_err);
    if (val_err == 0 && proto_err == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

//--- tb_axi_rd_demux_properties.sv
`timescale 1ns/10ps

module tb_axi_rd_demux_properties #(
  parameter int unsigned NUM_PORTS  = axi_rd_demux_pkg::NUM_PORTS_DEF,
  parameter int unsigned ID_WIDTH   = axi_rd_demux_pkg::ID_WIDTH_DEF,
  parameter int unsigned DATA_WIDTH = axi_rd_demux_pkg::DATA_WIDTH_DEF
) (
  input logic                                    clk_i,
  input logic                                    rst_i,
  input logic [NUM_PORTS-1:0]                    mst_ar_valid_o,
  input logic [NUM_PORTS-1:0]                    mst_ar_ready_i,
  input logic                                    slv_r_valid_o,
  input logic                                    slv_r_ready_i,
  input logic [ID_WIDTH-1:0]                     slv_r_id_o,
  input logic [DATA_WIDTH-1:0]                   slv_r_data_o,
  input logic [axi_rd_demux_pkg::RESP_WIDTH-1:0] slv_r_resp_o,
  input logic                                    slv_r_last_o
);

  // at most one master port sees an AR at a time
  ar_onehot: assert property (@(posedge clk_i) disable iff (rst_i)
    $onehot0(mst_ar_valid_o))
    else $error("mst_ar_valid_o has more than one bit set");

  // a shown master valid is never withdrawn before ready
  for (genvar g = 0; g < NUM_PORTS; g++) begin : gen_ar_hold
    ar_valid_held: assert property (@(posedge clk_i) disable iff (rst_i)
      mst_ar_valid_o[g] && !mst_ar_ready_i[g] |=> mst_ar_valid_o[g])
      else $error("mst_ar_valid_o dropped without ready");
  end

  // slave R beat frozen under back-pressure
  r_stable: assert property (@(posedge clk_i) disable iff (rst_i)
    slv_r_valid_o && !slv_r_ready_i |=>
      slv_r_valid_o && $stable(slv_r_id_o) && $stable(slv_r_data_o) &&
      $stable(slv_r_resp_o) && $stable(slv_r_last_o))
    else $error("slave R beat changed while stalled");

endmodule

bind axi_rd_demux tb_axi_rd_demux_properties #(
  .NUM_PORTS  (NUM_PORTS),
  .ID_WIDTH   (ID_WIDTH),
  .DATA_WIDTH (DATA_WIDTH)
) u_props (
  .clk_i          (clk_i),
  .rst_i          (rst_i),
  .mst_ar_valid_o (mst_ar_valid_o),
  .mst_ar_ready_i (mst_ar_ready_i),
  .slv_r_valid_o  (slv_r_valid_o),
  .slv_r_ready_i  (slv_r_ready_i),
  .slv_r_id_o     (slv_r_id_o),
  .slv_r_data_o   (slv_r_data_o),
  .slv_r_resp_o   (slv_r_resp_o),
  .slv_r_last_o   (slv_r_last_o)
);

//--- verilog.f
axi_rd_demux_pkg.sv
rd_id_counters.sv
ar_route_ctrl.sv
r_rr_arbiter.sv
axi_rd_demux.sv
tb_axi_rd_demux_properties.sv
tb_axi_rd_demux.sv
